// ==== Makefile ====
# Verilator build for the JTAG UART link

VERILATOR  ?= verilator
TOP        ?= tb_jtag_uart_sys
RTL_TOP    ?= jtag_uart_sys
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
RTL_SRCS := $(filter rtl/%,$(SRCS))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== rtl/char_fifo.sv ====
// char_fifo
//   circular-buffer FIFO with occupancy count
//   head shows the oldest entry, push on full and pop on empty are ignored
module char_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 8
) (
    input  logic             jtag_clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] head,
    output logic             empty,
    output logic             full,
    output logic [15:0]      count
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [15:0]      count_q;
    logic             wr_en;
    logic             rd_en;

    assign empty = (count_q == 16'd0);
    assign full  = (count_q == 16'(DEPTH));
    assign count = count_q;
    assign head  = mem[rd_ptr];

    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        if (ptr == AW'(DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge jtag_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= next_ptr(wr_ptr);
            if (rd_en)
                rd_ptr <= next_ptr(rd_ptr);
            // simultaneous push and pop leaves the count unchanged
            if (wr_en && !rd_en)
                count_q <= count_q + 16'd1;
            else if (rd_en && !wr_en)
                count_q <= count_q - 16'd1;
        end
    end

    always_ff @(posedge jtag_clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= push_data;
    end

    // callers never push a full FIFO or pop an empty one
    a_no_push_full: assert property (@(posedge jtag_clk) disable iff (!rst_n)
        !(push && full));
    a_no_pop_empty: assert property (@(posedge jtag_clk) disable iff (!rst_n)
        !(pop && empty));

endmodule

// ==== rtl/jtag_uart_host.sv ====
// jtag_uart_host
//   debug-side agent for the JTAG UART slave
//   queues outgoing characters, polls data register 0 on a timer,
//   writes a character only when the last seen write space is nonzero
//   and emits each received character as a one-cycle strobe
module jtag_uart_host #(
    parameter int POLL_INTERVAL = 64,
    parameter int QUEUE_DEPTH   = 16
) (
    input  logic                  jtag_clk,
    input  logic                  rst_n,
    input  logic                  tx_stb,
    input  jtag_uart_pkg::char_t  tx_char,
    output logic                  tx_full,
    output logic                  rx_stb,
    output jtag_uart_pkg::char_t  rx_char,
    output jtag_uart_pkg::j2wb_t  req,
    input  jtag_uart_pkg::wb2j_t  rsp
);

    import jtag_uart_pkg::*;

    host_state_t     state;
    logic            stb_q;
    logic            we_q;
    logic [j_dw-1:0] dat_q;
    wspace_t         wspace_known;
    logic [15:0]     poll_cnt;
    logic            poll_due;

    char_t           q_head;
    logic            q_empty;
    logic            q_full;
    logic            q_push;
    logic            q_pop;

    logic            send_ok;
    logic            poll_go;
    logic            ack_seen;
    data_reg_t       rd;

    // outgoing character queue
    char_fifo #(
        .DEPTH (QUEUE_DEPTH),
        .WIDTH ($bits(char_t))
    ) queue0 (
        .jtag_clk  (jtag_clk),
        .rst_n     (rst_n),
        .push      (q_push),
        .push_data (tx_char),
        .pop       (q_pop),
        .head      (q_head),
        .empty     (q_empty),
        .full      (q_full),
        .count     ()
    );

    // a strobe into a full queue is lost
    assign q_push  = tx_stb && !q_full;
    assign tx_full = q_full;

    assign poll_due = (poll_cnt >= 16'(POLL_INTERVAL - 1));
    assign send_ok  = (state == idle) && !q_empty && (wspace_known != '0);
    assign poll_go  = (state == idle) && !send_ok && poll_due;
    assign ack_seen = (state == request) && rsp.ack;
    assign q_pop    = send_ok;

    assign rd  = data_reg_t'(rsp.dat);
    assign req = '{addr: data_reg0_addr, stb: stb_q, we: we_q, dat: dat_q};

    always_ff @(posedge jtag_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state        <= idle;
            stb_q        <= 1'b0;
            we_q         <= 1'b0;
            wspace_known <= '0;
            poll_cnt     <= '0;
            rx_stb       <= 1'b0;
        end
        else
        begin
            rx_stb <= 1'b0;
            // timer keeps running during an access
            if (!poll_due)
                poll_cnt <= poll_cnt + 16'd1;

            case (state)
                idle:
                begin
                    if (send_ok || poll_go)
                    begin
                        stb_q    <= 1'b1;
                        we_q     <= send_ok;
                        poll_cnt <= '0;
                        state    <= request;
                    end
                end
                request:
                begin
                    if (rsp.ack)
                    begin
                        // reported space predates our own write
                        if (we_q && (rd.wspace != '0))
                            wspace_known <= rd.wspace - wspace_t'(1);
                        else
                            wspace_known <= rd.wspace;
                        rx_stb <= rd.rvalid;
                        state  <= finish;
                    end
                end
                finish:
                begin
                    stb_q <= 1'b0;
                    state <= idle;
                end
                default:
                begin
                    stb_q <= 1'b0;
                    state <= idle;
                end
            endcase
        end
    end

    // data path registers
    always_ff @(posedge jtag_clk)
    begin
        if (send_ok)
            dat_q <= j_dw'(q_head);
        if (ack_seen)
            rx_char <= rd.ch;
    end

    // request held stable until the slave answers
    a_stb_until_ack: assert property (@(posedge jtag_clk) disable iff (!rst_n)
        $rose(req.stb) |-> req.stb throughout rsp.ack[->1]);

endmodule

// ==== rtl/jtag_uart_pkg.sv ====
// shared definitions for the JTAG UART link
//   bus widths and the register-0 address
//   request and response bus structs
//   register-0 word layout
//   host agent states and status bit names
package jtag_uart_pkg;

    localparam int j_aw      = 32;
    localparam int j_dw      = 32;
    localparam int j_statusw = 8;
    localparam int j_indexw  = 8;

    // only data register 0 is decoded
    localparam logic [j_aw-1:0] data_reg0_addr = '0;

    typedef logic [7:0]  char_t;
    typedef logic [15:0] wspace_t;

    // host agent to slave, 66 bits
    typedef struct packed {
        logic [j_aw-1:0] addr;
        logic            stb;
        logic            we;
        logic [j_dw-1:0] dat;
    } j2wb_t;

    // slave to host agent, 49 bits
    typedef struct packed {
        logic [j_statusw-1:0] status;
        logic                 ack;
        logic [j_dw-1:0]      dat;
        logic [j_indexw-1:0]  index;
    } wb2j_t;

    // register-0 word, upper bits read as zero
    typedef struct packed {
        logic [6:0] pad;
        logic       rvalid;
        wspace_t    wspace;
        char_t      ch;
    } data_reg_t;

    typedef enum logic [1:0] {
        idle,
        request,
        finish
    } host_state_t;

    // bit positions within the status field
    typedef enum int unsigned {
        bad_addr = 0
    } status_bit_e;

endpackage

// ==== rtl/jtag_uart_slave.sv ====
// jtag_uart_slave
//   data register 0 behind the request/response bus
//   host-to-device and device-to-host character FIFOs
//   plain character interface on the device side
module jtag_uart_slave #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  jtag_clk,
    input  logic                  rst_n,
    input  jtag_uart_pkg::j2wb_t  req,
    output jtag_uart_pkg::wb2j_t  rsp,
    input  logic                  dev_tx_stb,
    input  jtag_uart_pkg::char_t  dev_tx_char,
    output logic                  dev_tx_full,
    output logic                  dev_rx_valid,
    output jtag_uart_pkg::char_t  dev_rx_char,
    input  logic                  dev_rx_pop
);

    import jtag_uart_pkg::*;

    logic                 stb_q;
    logic                 ack_q;
    logic [j_statusw-1:0] status_q;
    logic [j_dw-1:0]      dat_q;
    logic [j_indexw-1:0]  index_q;

    logic                 access_go;
    logic                 reg0_hit;
    data_reg_t            rsp_word;

    char_t                h2d_head;
    logic                 h2d_empty;
    logic [15:0]          h2d_count;
    logic                 h2d_push;
    logic                 h2d_pop;

    char_t                d2h_head;
    logic                 d2h_empty;
    logic                 d2h_full;
    logic                 d2h_push;
    logic                 d2h_pop;

    // host to device
    char_fifo #(
        .DEPTH (FIFO_DEPTH),
        .WIDTH ($bits(char_t))
    ) h2d_fifo (
        .jtag_clk  (jtag_clk),
        .rst_n     (rst_n),
        .push      (h2d_push),
        .push_data (req.dat[7:0]),
        .pop       (h2d_pop),
        .head      (h2d_head),
        .empty     (h2d_empty),
        .full      (),
        .count     (h2d_count)
    );

    // device to host
    char_fifo #(
        .DEPTH (FIFO_DEPTH),
        .WIDTH ($bits(char_t))
    ) d2h_fifo (
        .jtag_clk  (jtag_clk),
        .rst_n     (rst_n),
        .push      (d2h_push),
        .push_data (dev_tx_char),
        .pop       (d2h_pop),
        .head      (d2h_head),
        .empty     (d2h_empty),
        .full      (d2h_full),
        .count     ()
    );

    // one access per rising edge of stb
    assign access_go = req.stb && !stb_q;
    assign reg0_hit  = (req.addr == data_reg0_addr);

    // word reflects the state before this access
    assign rsp_word = '{
        pad:    '0,
        rvalid: !d2h_empty,
        wspace: wspace_t'(FIFO_DEPTH) - h2d_count,
        ch:     d2h_empty ? char_t'(0) : d2h_head
    };

    assign d2h_pop  = access_go && reg0_hit && !d2h_empty;
    // host only writes after seeing space, no full check here
    assign h2d_push = access_go && reg0_hit && req.we;

    assign d2h_push     = dev_tx_stb && !d2h_full;
    // device pops only while dev_rx_valid is high
    assign h2d_pop      = dev_rx_pop;
    assign dev_tx_full  = d2h_full;
    assign dev_rx_valid = !h2d_empty;
    assign dev_rx_char  = h2d_head;

    assign rsp = '{status: status_q, ack: ack_q, dat: dat_q, index: index_q};

    always_ff @(posedge jtag_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            stb_q    <= 1'b0;
            ack_q    <= 1'b0;
            status_q <= '0;
        end
        else
        begin
            stb_q <= req.stb;
            ack_q <= access_go;
            if (access_go)
            begin
                status_q <= '0;
                if (!reg0_hit)
                    status_q[bad_addr] <= 1'b1;
            end
        end
    end

    always_ff @(posedge jtag_clk)
    begin
        if (access_go)
        begin
            dat_q   <= reg0_hit ? j_dw'(rsp_word) : '0;
            index_q <= req.addr[j_indexw-1:0];
        end
    end

    a_ack_one_cycle: assert property (@(posedge jtag_clk) disable iff (!rst_n)
        rsp.ack |=> !rsp.ack);

endmodule

// ==== rtl/jtag_uart_sys.sv ====
// jtag_uart_sys
//   top level of the JTAG UART link
//   host agent and register-0 slave joined by the request/response bus
module jtag_uart_sys #(
    parameter int POLL_INTERVAL = 64,
    parameter int QUEUE_DEPTH   = 16,
    parameter int FIFO_DEPTH    = 8
) (
    input  logic                  jtag_clk,
    input  logic                  rst_n,
    input  logic                  host_tx_stb,
    input  jtag_uart_pkg::char_t  host_tx_char,
    output logic                  host_tx_full,
    output logic                  host_rx_stb,
    output jtag_uart_pkg::char_t  host_rx_char,
    input  logic                  dev_tx_stb,
    input  jtag_uart_pkg::char_t  dev_tx_char,
    output logic                  dev_tx_full,
    output logic                  dev_rx_valid,
    output jtag_uart_pkg::char_t  dev_rx_char,
    input  logic                  dev_rx_pop
);

    import jtag_uart_pkg::*;

    j2wb_t req;
    wb2j_t rsp;

    // debug side
    jtag_uart_host #(
        .POLL_INTERVAL (POLL_INTERVAL),
        .QUEUE_DEPTH   (QUEUE_DEPTH)
    ) host0 (
        .jtag_clk (jtag_clk),
        .rst_n    (rst_n),
        .tx_stb   (host_tx_stb),
        .tx_char  (host_tx_char),
        .tx_full  (host_tx_full),
        .rx_stb   (host_rx_stb),
        .rx_char  (host_rx_char),
        .req      (req),
        .rsp      (rsp)
    );

    // device side
    jtag_uart_slave #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) slave0 (
        .jtag_clk     (jtag_clk),
        .rst_n        (rst_n),
        .req          (req),
        .rsp          (rsp),
        .dev_tx_stb   (dev_tx_stb),
        .dev_tx_char  (dev_tx_char),
        .dev_tx_full  (dev_tx_full),
        .dev_rx_valid (dev_rx_valid),
        .dev_rx_char  (dev_rx_char),
        .dev_rx_pop   (dev_rx_pop)
    );

endmodule

// ==== verification/tb_jtag_uart_sys.sv ====
// tb_jtag_uart_sys
//   directed testbench for the JTAG UART link
//   clock, reset, device-side responder and host receive monitor
//   stream models for both directions, one task per behavior
module tb_jtag_uart_sys;

    timeunit 1ns;
    timeprecision 100ps;

    import jtag_uart_pkg::*;

    localparam int POLL_INTERVAL = 16;
    localparam int QUEUE_DEPTH   = 8;
    localparam int FIFO_DEPTH    = 4;
    localparam int RX_LIMIT      = POLL_INTERVAL + 4;
    localparam int LONG_LIMIT    = 2000;

    logic  jtag_clk;
    logic  rst_n;
    logic  host_tx_stb;
    char_t host_tx_char;
    logic  host_tx_full;
    logic  host_rx_stb;
    char_t host_rx_char;
    logic  dev_tx_stb;
    char_t dev_tx_char;
    logic  dev_tx_full;
    logic  dev_rx_valid;
    char_t dev_rx_char;
    logic  dev_rx_pop = 1'b0;
    logic  dev_pop_en = 1'b0;

    // expected and observed streams
    char_t exp_dev[$];
    char_t got_dev[$];
    char_t exp_host[$];
    char_t got_host[$];

    jtag_uart_sys #(
        .POLL_INTERVAL (POLL_INTERVAL),
        .QUEUE_DEPTH   (QUEUE_DEPTH),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) dut0 (
        .jtag_clk     (jtag_clk),
        .rst_n        (rst_n),
        .host_tx_stb  (host_tx_stb),
        .host_tx_char (host_tx_char),
        .host_tx_full (host_tx_full),
        .host_rx_stb  (host_rx_stb),
        .host_rx_char (host_rx_char),
        .dev_tx_stb   (dev_tx_stb),
        .dev_tx_char  (dev_tx_char),
        .dev_tx_full  (dev_tx_full),
        .dev_rx_valid (dev_rx_valid),
        .dev_rx_char  (dev_rx_char),
        .dev_rx_pop   (dev_rx_pop)
    );

    always #2 jtag_clk = ~jtag_clk;

    // device responder pops one character per cycle when enabled
    always @(negedge jtag_clk)
    begin
        if (host_rx_stb)
            got_host.push_back(host_rx_char);
        if (rst_n && dev_pop_en && dev_rx_valid)
        begin
            got_dev.push_back(dev_rx_char);
            dev_rx_pop = 1'b1;
        end
        else
        begin
            dev_rx_pop = 1'b0;
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_char(input string what, input char_t exp, input char_t act);
        if (act !== exp)
            fail_run($sformatf("FAIL %s expected 0x%02h actual 0x%02h", what, exp, act));
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("FAIL %s expected %b actual %b", what, exp, act));
    endtask

    // strobe stays high until the next strobe or clear_strobes
    task automatic strobe_host(input char_t c);
        @(negedge jtag_clk);
        host_tx_stb  = 1'b1;
        host_tx_char = c;
        exp_dev.push_back(c);
    endtask

    task automatic strobe_dev(input char_t c);
        @(negedge jtag_clk);
        dev_tx_stb  = 1'b1;
        dev_tx_char = c;
        exp_host.push_back(c);
    endtask

    task automatic clear_strobes();
        @(negedge jtag_clk);
        host_tx_stb = 1'b0;
        dev_tx_stb  = 1'b0;
    endtask

    task automatic wait_stream(input bit to_dev, input int n, input int limit,
                               input string what);
        int cycles;
        cycles = 0;
        while ((to_dev ? got_dev.size() : got_host.size()) < n)
        begin
            @(posedge jtag_clk);
            cycles++;
            if (cycles > limit)
                fail_run($sformatf("%s: no character arrived within %0d cycles", what, limit));
        end
    endtask

    task automatic compare_stream(input bit to_dev, input string what);
        char_t e;
        char_t a;
        int    n_exp;
        int    n_got;
        n_exp = to_dev ? exp_dev.size() : exp_host.size();
        n_got = to_dev ? got_dev.size() : got_host.size();
        if (n_got != n_exp)
            fail_run($sformatf("%s: expected %0d characters but %0d arrived",
                               what, n_exp, n_got));
        for (int i = 0; i < n_exp; i++)
        begin
            if (to_dev)
            begin
                e = exp_dev.pop_front();
                a = got_dev.pop_front();
            end
            else
            begin
                e = exp_host.pop_front();
                a = got_host.pop_front();
            end
            check_char($sformatf("%s[%0d]", what, i), e, a);
        end
    endtask

    task automatic check_reset_state();
        repeat (2 * POLL_INTERVAL)
        begin
            @(negedge jtag_clk);
            check_flag("reset_host_rx_stb", 1'b0, host_rx_stb);
            check_flag("reset_dev_rx_valid", 1'b0, dev_rx_valid);
            check_flag("reset_host_tx_full", 1'b0, host_tx_full);
            check_flag("reset_dev_tx_full", 1'b0, dev_tx_full);
        end
    endtask

    task automatic send_host_string();
        string s;
        s = "XYZXYZ";
        dev_pop_en = 1'b1;
        for (int i = 0; i < s.len(); i++)
            strobe_host(char_t'(s[i]));
        clear_strobes();
        wait_stream(1'b1, s.len(), LONG_LIMIT, "host_string");
        compare_stream(1'b1, "host_string");
    endtask

    // one character at a time so each latency is measured alone
    task automatic send_dev_string();
        string s;
        s = "dev>ok";
        for (int i = 0; i < s.len(); i++)
        begin
            strobe_dev(char_t'(s[i]));
            clear_strobes();
            check_flag("dev_string_full", 1'b0, dev_tx_full);
            wait_stream(1'b0, i + 1, RX_LIMIT, "dev_string");
        end
        compare_stream(1'b0, "dev_string");
    endtask

    task automatic stall_device_fifo();
        int cycles;
        dev_pop_en = 1'b0;
        for (int i = 0; i < 8; i++)
            strobe_host(char_t'($urandom));
        clear_strobes();
        repeat (3 * POLL_INTERVAL) @(negedge jtag_clk);
        check_flag("flow_valid", 1'b1, dev_rx_valid);
        check_char("flow_head", exp_dev[0], dev_rx_char);
        check_flag("flow_full", 1'b0, host_tx_full);
        // first burst of pops drains only what the device FIFO held
        dev_pop_en = 1'b1;
        cycles     = 0;
        while (dev_rx_valid)
        begin
            @(negedge jtag_clk);
            cycles++;
            if (cycles > LONG_LIMIT)
                fail_run("flow_control: dev_rx_valid never fell while the device popped");
        end
        if (got_dev.size() > FIFO_DEPTH)
            fail_run($sformatf("flow_control: %0d characters were visible, at most %0d fit",
                               got_dev.size(), FIFO_DEPTH));
        wait_stream(1'b1, 8, LONG_LIMIT, "flow_control");
        compare_stream(1'b1, "flow_control");
    endtask

    task automatic run_random_traffic();
        dev_pop_en = 1'b1;
        for (int i = 0; i < 120; i++)
        begin
            @(negedge jtag_clk);
            host_tx_stb  = ($urandom_range(2, 0) == 0) && !host_tx_full;
            host_tx_char = char_t'($urandom);
            dev_tx_stb   = ($urandom_range(5, 0) == 0) && !dev_tx_full;
            dev_tx_char  = char_t'($urandom);
            if (host_tx_stb)
                exp_dev.push_back(host_tx_char);
            if (dev_tx_stb)
                exp_host.push_back(dev_tx_char);
        end
        clear_strobes();
        wait_stream(1'b1, exp_dev.size(), LONG_LIMIT, "random_to_dev");
        wait_stream(1'b0, exp_host.size(), LONG_LIMIT, "random_to_host");
        compare_stream(1'b1, "random_to_dev");
        compare_stream(1'b0, "random_to_host");
    endtask

    // slave FIFO fills first, then the host queue
    task automatic fill_host_queue();
        int pending;
        bit model_full;
        pending    = 0;
        dev_pop_en = 1'b0;
        for (int i = 0; i < FIFO_DEPTH; i++)
        begin
            strobe_host(char_t'($urandom));
            pending++;
        end
        clear_strobes();
        repeat (3 * POLL_INTERVAL) @(negedge jtag_clk);
        for (int i = 0; i < QUEUE_DEPTH; i++)
        begin
            strobe_host(char_t'($urandom));
            pending++;
        end
        clear_strobes();
        model_full = (pending >= FIFO_DEPTH + QUEUE_DEPTH);
        check_flag("queue_full", model_full, host_tx_full);
        // extra strobe is kept only when the model has room
        @(negedge jtag_clk);
        host_tx_stb  = 1'b1;
        host_tx_char = char_t'($urandom);
        if (!model_full)
        begin
            exp_dev.push_back(host_tx_char);
            pending++;
        end
        clear_strobes();
        check_flag("queue_full_hold", model_full, host_tx_full);
        dev_pop_en = 1'b1;
        wait_stream(1'b1, pending, LONG_LIMIT, "queue_full");
        repeat (2 * POLL_INTERVAL) @(posedge jtag_clk);
        compare_stream(1'b1, "queue_full");
        check_flag("queue_drained", 1'b0, host_tx_full);
    endtask

    initial
    begin
        void'($urandom(32'h7a2e_4d3b));
        jtag_clk     = 1'b0;
        rst_n        = 1'b0;
        host_tx_stb  = 1'b0;
        host_tx_char = '0;
        dev_tx_stb   = 1'b0;
        dev_tx_char  = '0;
        repeat (3) @(posedge jtag_clk);
        @(negedge jtag_clk);
        rst_n = 1'b1;

        check_reset_state();
        send_host_string();
        send_dev_string();
        stall_device_fifo();
        run_random_traffic();
        fill_host_queue();

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/jtag_uart_pkg.sv
rtl/char_fifo.sv
rtl/jtag_uart_host.sv
rtl/jtag_uart_slave.sv
rtl/jtag_uart_sys.sv
verification/tb_jtag_uart_sys.sv
